/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam logic [31:0] reset_pc = 32'h0000_0100;  // first fetch address
    localparam int ram_words = 1024;                    // depth in 32-bit words
    localparam int ram_addr_w = $clog2(ram_words);      // word address bits
    localparam int nibbles_per_word = 8;                // alu passes per word
    localparam int nib_cnt_w = $clog2(nibbles_per_word);

    // rv32i major opcodes, the supported subset
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,  // b inverted, carry preset
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4
    } alu_op_e;

    typedef enum logic [3:0] {
        st_reset      = 4'd0,
        st_fetch      = 4'd1,  // ram read issued
        st_fetch_wait = 4'd2,  // instruction word arrives
        st_decode     = 4'd3,
        st_exec       = 4'd4,  // one or two alu passes
        st_mem        = 4'd5,
        st_mem_wait   = 4'd6,
        st_wb         = 4'd7,  // retire cycle
        st_trap       = 4'd8
    } state_e;

endpackage

/* rtl/unified_ram.sv */
module unified_ram (
    input  logic                          clk,
    input  logic                          en,
    input  logic                          we,
    input  logic [cpu_pkg::ram_addr_w-1:0] addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata
);

    logic [31:0] mem [0:cpu_pkg::ram_words-1];  // code and data together

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // valid next cycle, held until next read
            end
        end
    end

endmodule

/* rtl/register_file.sv */
module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rs2_idx,
    input  logic        we,
    input  logic [4:0]  rd_idx,
    input  logic [31:0] rd_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_idx != 5'd0)) begin
            regs[rd_idx] <= rd_data;  // x0 writes dropped
        end
    end

    // combinational reads, x0 reads as zero
    assign rs1_data = (rs1_idx == 5'd0) ? 32'd0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? 32'd0 : regs[rs2_idx];

endmodule

/* rtl/nibble_alu.sv */
module nibble_alu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  cpu_pkg::alu_op_e op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      result,
    output logic             done
);

    logic [31:0]                   a_sr;      // operand a, low nibble first
    logic [31:0]                   b_sr;      // operand b, already inverted for sub
    logic [31:0]                   r_sr;      // result nibbles enter at the top
    logic [31:0]                   b_eff;
    logic [31:0]                   a_src;
    logic [31:0]                   b_src;
    logic [cpu_pkg::nib_cnt_w-1:0] cnt;       // nibbles done so far
    logic                          busy;
    logic                          carry;     // carry between passes
    logic                          c_in;
    logic [4:0]                    sum;       // 4-bit slice plus carry out
    logic [3:0]                    nib;
    cpu_pkg::alu_op_e              op_q;
    cpu_pkg::alu_op_e              op_cur;

    assign b_eff  = (op == cpu_pkg::sub) ? ~b : b;
    assign a_src  = start ? a : a_sr;      // first nibble straight from inputs
    assign b_src  = start ? b_eff : b_sr;
    assign op_cur = start ? op : op_q;
    assign c_in   = start ? (op == cpu_pkg::sub) : carry;
    assign sum    = {1'b0, a_src[3:0]} + {1'b0, b_src[3:0]} + {4'b0, c_in};

    always_comb begin
        case (op_cur)
            cpu_pkg::and_op: nib = a_src[3:0] & b_src[3:0];
            cpu_pkg::or_op:  nib = a_src[3:0] | b_src[3:0];
            cpu_pkg::xor_op: nib = a_src[3:0] ^ b_src[3:0];
            default:         nib = sum[3:0];  // add and sub
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            carry <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;  // single-cycle pulse
            if (start) begin
                busy  <= 1'b1;
                cnt   <= cpu_pkg::nib_cnt_w'(1);
                carry <= sum[4];
            end else if (busy) begin
                carry <= sum[4];
                cnt   <= cnt + 1'b1;
                if (cnt == cpu_pkg::nib_cnt_w'(cpu_pkg::nibbles_per_word - 1)) begin
                    busy <= 1'b0;  // last nibble shifted in
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            a_sr <= {4'b0, a_src[31:4]};
            b_sr <= {4'b0, b_src[31:4]};
            r_sr <= {nib, r_sr[31:4]};  // holds once idle
        end
        if (start) begin
            op_q <= op;
        end
    end

    assign result = r_sr;

endmodule

/* rtl/cpu_control.sv */
module cpu_control (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [31:0]                    mem_rdata,
    input  logic [31:0]                    rs1_data,
    input  logic [31:0]                    rs2_data,
    input  logic [31:0]                    alu_result,
    input  logic                           alu_done,
    output logic                           mem_en,
    output logic                           mem_we,
    output logic [cpu_pkg::ram_addr_w-1:0] mem_addr,
    output logic [31:0]                    mem_wdata,
    output logic [4:0]                     rs1_idx,
    output logic [4:0]                     rs2_idx,
    output logic                           rd_we,
    output logic [4:0]                     rd_idx,
    output logic [31:0]                    rd_data,
    output logic                           alu_start,
    output cpu_pkg::alu_op_e               alu_op,
    output logic [31:0]                    alu_a,
    output logic [31:0]                    alu_b,
    output logic                           retire,
    output logic [31:0]                    retire_pc,
    output logic [4:0]                     retire_rd,
    output logic [31:0]                    retire_value,
    output logic [31:0]                    retire_next_pc,
    output logic                           trap
);

    cpu_pkg::state_e  state;
    cpu_pkg::alu_op_e fn_op;      // op for arithmetic and logic opcodes
    logic [31:0] pc;
    logic [31:0] ir;              // instruction register
    logic [31:0] res0;            // first pass result
    logic [31:0] tgt;             // second pass result, jump or branch target
    logic        pass;            // 0 first pass, 1 second
    logic        busy;            // alu pass outstanding
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]  funct3;
    logic        is_op, is_load, is_store;
    logic        fn_ok;
    logic        legal;
    logic        two_pass;
    logic        writes_rd;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;

    assign funct3   = ir[14:12];
    assign is_op    = (ir[6:0] == cpu_pkg::op);
    assign is_load  = (ir[6:0] == cpu_pkg::load);
    assign is_store = (ir[6:0] == cpu_pkg::store);
    assign imm_i    = {{20{ir[31]}}, ir[31:20]};
    assign imm_s    = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b    = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u    = {ir[31:12], 12'b0};
    assign imm_j    = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        fn_op = cpu_pkg::add;
        fn_ok = 1'b1;
        case (funct3)
            3'b000:  fn_op = (is_op && ir[30]) ? cpu_pkg::sub : cpu_pkg::add;
            3'b100:  fn_op = cpu_pkg::xor_op;
            3'b110:  fn_op = cpu_pkg::or_op;
            3'b111:  fn_op = cpu_pkg::and_op;
            default: fn_ok = 1'b0;  // shifts and compares not supported
        endcase
        if (is_op && ((ir[31:25] & 7'b1011111) != 7'd0 || (ir[30] && funct3 != 3'b000)))
            fn_ok = 1'b0;  // only sub may set funct7 bit 5
    end

    // operand select per opcode and pass
    always_comb begin
        alu_a     = rs1_data;
        alu_b     = imm_i;
        alu_op    = cpu_pkg::add;
        two_pass  = 1'b0;
        writes_rd = 1'b1;
        legal     = 1'b1;
        case (ir[6:0])
            cpu_pkg::op_imm: begin
                alu_op = fn_op;
                legal  = fn_ok;
            end
            cpu_pkg::op: begin
                alu_b  = rs2_data;
                alu_op = fn_op;
                legal  = fn_ok;
            end
            cpu_pkg::load:  legal = (funct3 == 3'b010);  // lw only
            cpu_pkg::store: begin
                alu_b     = imm_s;
                writes_rd = 1'b0;
                legal     = (funct3 == 3'b010);
            end
            cpu_pkg::lui: begin
                alu_a = 32'd0;
                alu_b = imm_u;
            end
            cpu_pkg::auipc: begin
                alu_a = pc;
                alu_b = imm_u;
            end
            cpu_pkg::jal: begin
                two_pass = 1'b1;
                alu_a    = pc;
                alu_b    = pass ? imm_j : 32'd4;  // link then target
            end
            cpu_pkg::jalr: begin
                two_pass = 1'b1;
                alu_a    = pass ? rs1_data : pc;
                alu_b    = pass ? imm_i : 32'd4;
                legal    = (funct3 == 3'b000);
            end
            cpu_pkg::branch: begin
                two_pass  = 1'b1;
                writes_rd = 1'b0;
                alu_a     = pass ? pc : rs1_data;
                alu_b     = pass ? imm_b : rs2_data;
                alu_op    = pass ? cpu_pkg::add : cpu_pkg::sub;  // compare then target
                legal     = (funct3[2:1] == 2'b00);                // beq, bne
            end
            default: legal = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign taken    = (res0 == 32'd0) ^ funct3[0];  // bne inverts

    always_comb begin
        case (ir[6:0])
            cpu_pkg::jal:    next_pc = tgt;
            cpu_pkg::jalr:   next_pc = {tgt[31:1], 1'b0};
            cpu_pkg::branch: next_pc = taken ? tgt : pc_plus4;
            default:         next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::st_reset;
            pc    <= cpu_pkg::reset_pc;
            pass  <= 1'b0;
            busy  <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::st_reset:      state <= cpu_pkg::st_fetch;
                cpu_pkg::st_fetch:      state <= cpu_pkg::st_fetch_wait;
                cpu_pkg::st_fetch_wait: state <= cpu_pkg::st_decode;
                cpu_pkg::st_decode: begin
                    pass  <= 1'b0;
                    state <= legal ? cpu_pkg::st_exec : cpu_pkg::st_trap;
                end
                cpu_pkg::st_exec: begin
                    if (alu_start) begin
                        busy <= 1'b1;
                    end else if (alu_done) begin
                        busy <= 1'b0;
                        if (two_pass && !pass)
                            pass <= 1'b1;  // restart for target
                        else if (is_load || is_store)
                            state <= cpu_pkg::st_mem;
                        else
                            state <= cpu_pkg::st_wb;
                    end
                end
                cpu_pkg::st_mem:      state <= cpu_pkg::st_mem_wait;
                cpu_pkg::st_mem_wait: state <= cpu_pkg::st_wb;
                cpu_pkg::st_wb: begin
                    pc    <= next_pc;
                    state <= cpu_pkg::st_fetch;
                end
                cpu_pkg::st_trap:     state <= cpu_pkg::st_trap;  // until reset
                default:              state <= cpu_pkg::st_trap;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::st_fetch_wait)
            ir <= mem_rdata;
        if (state == cpu_pkg::st_exec && alu_done && !pass)
            res0 <= alu_result;
        if (state == cpu_pkg::st_exec && alu_done && pass)
            tgt <= alu_result;
    end

    assign alu_start = (state == cpu_pkg::st_exec) && !busy;
    assign mem_en    = (state == cpu_pkg::st_fetch) || (state == cpu_pkg::st_mem);
    assign mem_we    = (state == cpu_pkg::st_mem) && is_store;
    assign mem_addr  = (state == cpu_pkg::st_mem) ? res0[cpu_pkg::ram_addr_w+1:2]
                                                  : pc[cpu_pkg::ram_addr_w+1:2];
    assign mem_wdata = rs2_data;
    assign rs1_idx   = ir[19:15];
    assign rs2_idx   = ir[24:20];
    assign rd_idx    = ir[11:7];
    assign rd_data   = is_load ? mem_rdata : res0;  // ram keeps lw word in wb
    assign rd_we     = (state == cpu_pkg::st_wb) && writes_rd;

    assign retire         = (state == cpu_pkg::st_wb);
    assign retire_pc      = pc;
    assign retire_rd      = writes_rd ? rd_idx : 5'd0;
    assign retire_value   = writes_rd ? rd_data : 32'd0;
    assign retire_next_pc = next_pc;
    assign trap           = (state == cpu_pkg::st_trap);

endmodule

/* rtl/cpu_top.sv */
module cpu_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_en,
    input  logic [cpu_pkg::ram_addr_w-1:0] load_addr,
    input  logic [31:0]                    load_data,
    output logic                           retire,
    output logic [31:0]                    retire_pc,
    output logic [4:0]                     retire_rd,
    output logic [31:0]                    retire_value,
    output logic [31:0]                    retire_next_pc,
    output logic                           trap
);

    logic                           mem_en, mem_we;
    logic [cpu_pkg::ram_addr_w-1:0] mem_addr;
    logic [31:0]                    mem_wdata, mem_rdata;
    logic                           ram_en, ram_we;
    logic [cpu_pkg::ram_addr_w-1:0] ram_addr;
    logic [31:0]                    ram_wdata;
    logic [4:0]                     rs1_idx, rs2_idx, rd_idx;
    logic [31:0]                    rs1_data, rs2_data, rd_data;
    logic                           rd_we;
    logic                           alu_start, alu_done;
    cpu_pkg::alu_op_e               alu_op;
    logic [31:0]                    alu_a, alu_b, alu_result;

    // load port owns the ram while load_en is high
    assign ram_en    = load_en | mem_en;
    assign ram_we    = load_en | mem_we;
    assign ram_addr  = load_en ? load_addr : mem_addr;
    assign ram_wdata = load_en ? load_data : mem_wdata;

    cpu_control u_cpu_control (
        .clk, .rst_n, .mem_rdata, .rs1_data, .rs2_data, .alu_result, .alu_done,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .rs1_idx, .rs2_idx,
        .rd_we, .rd_idx, .rd_data, .alu_start, .alu_op, .alu_a, .alu_b,
        .retire, .retire_pc, .retire_rd, .retire_value, .retire_next_pc, .trap
    );

    nibble_alu u_nibble_alu (
        .clk, .rst_n,
        .start  (alu_start),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .done   (alu_done)
    );

    register_file u_register_file (
        .clk, .rst_n, .rs1_idx, .rs2_idx,
        .we       (rd_we),
        .rd_idx, .rd_data, .rs1_data, .rs2_data
    );

    unified_ram u_unified_ram (
        .clk,
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* testbench/cpu_sva.sv */
module cpu_sva (
    input logic clk,
    input logic rst_n,
    input logic retire,
    input logic alu_start,
    input logic alu_done,
    input logic trap
);

    // one retire pulse per instruction
    a_retire_single: assert property (@(posedge clk) disable iff (!rst_n)
        retire |=> !retire)
        else $error("retire high on two consecutive cycles");

    // fixed alu latency, one nibble per cycle
    a_alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
        alu_start |-> ##(cpu_pkg::nibbles_per_word) alu_done)
        else $error("alu_done not seen nibbles_per_word cycles after alu_start");

    a_alu_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        alu_start |=> (!alu_start throughout alu_done [-> 1]))
        else $error("alu_start pulsed while a pass was outstanding");

    a_trap_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        trap |=> trap)  // only reset leaves st_trap
        else $error("trap fell without reset");

endmodule

bind cpu_control cpu_sva u_cpu_sva (
    .clk, .rst_n, .retire, .alu_start, .alu_done, .trap
);

/* testbench/tb_cpu_top.sv */
module tb_cpu_top;

    logic                           clk;
    logic                           rst_n;
    logic                           load_en;
    logic [cpu_pkg::ram_addr_w-1:0] load_addr;
    logic [31:0]                    load_data;
    logic                           retire;
    logic [31:0]                    retire_pc;
    logic [4:0]                     retire_rd;
    logic [31:0]                    retire_value;
    logic [31:0]                    retire_next_pc;
    logic                           trap;

    logic [31:0] prog_addr [$];  // word addresses of the P records
    logic [31:0] prog_word [$];
    logic [31:0] exp_pc    [$];  // E records in retire order
    logic [4:0]  exp_rd    [$];
    logic [31:0] exp_value [$];
    logic [31:0] exp_next  [$];

    cpu_top u_cpu_top (
        .clk, .rst_n, .load_en, .load_addr, .load_data,
        .retire, .retire_pc, .retire_rd, .retire_value, .retire_next_pc, .trap
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;  // period 10

    task automatic report_failure;
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            report_failure();
        end
    endtask

    task automatic read_testdata;
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [31:0]      f0, f1, f2, f3;
        logic [8*128-1:0] rest;
        fd = $fopen("testbench/cpu_testdata.txt", "r");
        assert (fd != 0) else begin
            $display("could not open testbench/cpu_testdata.txt");
            report_failure();
        end
        while ($fscanf(fd, " %c", tag) == 1) begin  // first char of each line
            if (tag == "P") begin
                code = $fscanf(fd, "%h %h", f0, f1);
                assert (code == 2) else begin
                    $display("malformed P record in testbench/cpu_testdata.txt");
                    report_failure();
                end
                prog_addr.push_back(f0);
                prog_word.push_back(f1);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                assert (code == 4) else begin
                    $display("malformed E record in testbench/cpu_testdata.txt");
                    report_failure();
                end
                exp_pc.push_back(f0);
                exp_rd.push_back(f1[4:0]);
                exp_value.push_back(f2);
                exp_next.push_back(f3);
            end else begin
                code = $fgets(rest, fd);  // rest of a comment line dropped
            end
        end
        $fclose(fd);
    endtask

    // outputs sampled on the falling edge away from the update edge
    task automatic wait_retire;
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (retire !== 1'b1) begin
            assert (trap !== 1'b1) else begin
                $display("core trapped at t=%0t while a retire was expected", $time);
                report_failure();
            end
            assert (cycles < 100) else begin
                $display("no retire within 100 cycles, t=%0t", $time);
                report_failure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_trap;
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (trap !== 1'b1) begin
            assert (retire !== 1'b1) else begin
                $display("unexpected retire at t=%0t, pc %h", $time, retire_pc);
                report_failure();
            end
            assert (cycles < 100) else begin
                $display("trap did not rise within 100 cycles, t=%0t", $time);
                report_failure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        read_testdata();
        for (int i = 0; i < prog_addr.size(); i++) begin  // core held in reset meanwhile
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = prog_addr[i][cpu_pkg::ram_addr_w-1:0];
            load_data = prog_word[i];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        repeat (5) @(posedge clk);  // 5 reset cycles past the load
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < exp_pc.size(); i++) begin
            wait_retire();
            compare_field("retire_pc", exp_pc[i], retire_pc);
            compare_field("retire_rd", {27'd0, exp_rd[i]}, {27'd0, retire_rd});
            compare_field("retire_value", exp_value[i], retire_value);
            compare_field("retire_next_pc", exp_next[i], retire_next_pc);
        end
        wait_trap();  // last word is an unsupported opcode
        repeat (20) begin
            @(negedge clk);
            assert (retire !== 1'b1 && trap === 1'b1) else begin
                $display("retire seen or trap dropped after the trap, t=%0t", $time);
                report_failure();
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* testbench/cpu_testdata.txt */
# P word_addr word            : RAM preload, word address and data in hex
# E pc rd value next_pc       : expected retire records in program order, hex
P 040 00500093
P 041 FFF00113
P 042 FFA08193
P 043 10000237
P 044 FFF20213
P 045 001202B3
P 046 40408333
P 047 004373B3
P 048 00626433
P 049 0062C4B3
P 04A CAFEC537
P 04B ABE50513
P 04C 20000593
P 04D 00A5A423
P 04E 0085A603
P 04F FFC5A683
P 050 12345717
P 051 008007EF
P 052 00000073
P 053 00D78867
P 054 00000073
P 055 00310463
P 056 00000073
P 057 00311463
P 058 00000073
P 07F 13579BDF
E 00000100 01 00000005 00000104
E 00000104 02 FFFFFFFF 00000108
E 00000108 03 FFFFFFFF 0000010C
E 0000010C 04 10000000 00000110
E 00000110 04 0FFFFFFF 00000114
E 00000114 05 10000004 00000118
E 00000118 06 F0000006 0000011C
E 0000011C 07 00000006 00000120
E 00000120 08 FFFFFFFF 00000124
E 00000124 09 E0000002 00000128
E 00000128 0A CAFEC000 0000012C
E 0000012C 0A CAFEBABE 00000130
E 00000130 0B 00000200 00000134
E 00000134 00 00000000 00000138
E 00000138 0C CAFEBABE 0000013C
E 0000013C 0D 13579BDF 00000140
E 00000140 0E 12345140 00000144
E 00000144 0F 00000148 0000014C
E 0000014C 10 00000150 00000154
E 00000154 00 00000000 0000015C
E 0000015C 00 00000000 00000160

/* src.f */
rtl/cpu_pkg.sv
rtl/unified_ram.sv
rtl/register_file.sv
rtl/nibble_alu.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
testbench/cpu_sva.sv
testbench/tb_cpu_top.sv

/* Bender.yml */
package:
  name: nibble_cpu

sources:
  - rtl/cpu_pkg.sv
  - rtl/unified_ram.sv
  - rtl/register_file.sv
  - rtl/nibble_alu.sv
  - rtl/cpu_control.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - testbench/cpu_sva.sv
      - testbench/tb_cpu_top.sv
